// File: Makefile
# Verilator flow for the iterative multiplier
# Override any variable on the command line, e.g. make sim LOG=run.log

VERILATOR ?= verilator
FILELIST  ?= fastmul.f
TOP       ?= fastmul_tb
RTL_TOP   ?= fastmul_top
BUILD_DIR ?= obj_dir
EXE       ?= V$(TOP)
LOG       ?= sim.log
PASS_MSG  ?= Everything OK
VFLAGS    ?=

.PHONY: all lint build sim clean

all: sim

# Lint the RTL on its own, then the whole bench
lint:
	$(VERILATOR) --lint-only $(VFLAGS) +incdir+rtl \
		rtl/fastmul_pkg.sv rtl/mult_sequencer.sv rtl/mult_mac.sv \
		rtl/mult_accum.sv rtl/fastmul_top.sv --top-module $(RTL_TOP)
	$(VERILATOR) --lint-only --timing $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

build:
	$(VERILATOR) --binary --timing $(VFLAGS) -f $(FILELIST) \
		--top-module $(TOP) -Mdir $(BUILD_DIR) -o $(EXE)

# The run passes only if the log holds the pass message
sim: build
	$(BUILD_DIR)/$(EXE) 2>&1 | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "Simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: bench/fastmul_tb.sv
/*
 * Testbench of the iterative multiplier. Applies a table of MUL and MULH
 * cases with back-pressure, enable gaps and back-to-back issue, and checks
 * each result and latency against a 64-bit reference product.
 */
`include "fastmul_settings.svh"

module fastmul_tb
  import fastmul_pkg::*;
();

  localparam int HALF_PERIOD  = 20;
  localparam int DRIVE_DLY    = 2;
  localparam int RESET_CYCLES = 16;
  localparam int MAX_ENTRIES  = 64;
  localparam int NUM_RANDOM   = 24;
  localparam int MAX_STALL    = 5;
  localparam int GAP_LEN      = 3;

  logic          clk_i;
  logic          rst_ni;
  logic          en_i;
  logic          ready_i;
  fm_op_e        op_i;
  fm_sign_mode_t sign_mode_i;
  fm_word_t      op_a_i;
  fm_word_t      op_b_i;
  fm_word_t      result_o;
  logic          valid_o;

  // Stimulus and expected values, one index per test
  string         tbl_name   [MAX_ENTRIES];
  fm_op_e        tbl_op     [MAX_ENTRIES];
  fm_sign_mode_t tbl_mode   [MAX_ENTRIES];
  fm_word_t      tbl_a      [MAX_ENTRIES];
  fm_word_t      tbl_b      [MAX_ENTRIES];
  fm_word_t      tbl_exp    [MAX_ENTRIES];
  int            tbl_cycles [MAX_ENTRIES];
  int            tbl_stall  [MAX_ENTRIES];
  logic          tbl_gap    [MAX_ENTRIES];
  int            num_entries;

  integer seed;
  bit     table_ready;
  int     checks;
  int     result_errors;
  int     cycle_errors;
  int     protocol_errors;

  fastmul_top uut (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .en_i       (en_i),
    .ready_i    (ready_i),
    .op_i       (op_i),
    .sign_mode_i(sign_mode_i),
    .op_a_i     (op_a_i),
    .op_b_i     (op_b_i),
    .result_o   (result_o),
    .valid_o    (valid_o)
  );

  always #HALF_PERIOD clk_i = ~clk_i;

  // Full product of the operands, each extended by its signed-mode bit
  function automatic fm_word_t expected_product(input fm_op_e op, input fm_sign_mode_t mode,
                                                input fm_word_t a, input fm_word_t b);
    logic [2*`FM_WORD_W-1:0] ext_a;
    logic [2*`FM_WORD_W-1:0] ext_b;
    logic [2*`FM_WORD_W-1:0] prod;
    ext_a = {{`FM_WORD_W{mode[0] & a[`FM_WORD_W-1]}}, a};
    ext_b = {{`FM_WORD_W{mode[1] & b[`FM_WORD_W-1]}}, b};
    prod  = ext_a * ext_b;
    if (op == FM_OP_MUL) begin
      return prod[`FM_WORD_W-1:0];
    end else begin
      return prod[2*`FM_WORD_W-1:`FM_WORD_W];
    end
  endfunction

  task automatic add_entry(input string name, input fm_op_e op, input fm_sign_mode_t mode,
                           input fm_word_t a, input fm_word_t b, input int stall,
                           input logic gap);
    int base;
    base = (op == FM_OP_MUL) ? `FM_MUL_CYCLES : `FM_MULH_CYCLES;
    if (num_entries >= MAX_ENTRIES) begin
      $display("Stimulus table is full, test %s was not added", name);
      protocol_errors++;
    end else begin
      tbl_name[num_entries]   = name;
      tbl_op[num_entries]     = op;
      tbl_mode[num_entries]   = mode;
      tbl_a[num_entries]      = a;
      tbl_b[num_entries]      = b;
      tbl_exp[num_entries]    = expected_product(op, mode, a, b);
      tbl_stall[num_entries]  = stall;
      tbl_gap[num_entries]    = gap;
      tbl_cycles[num_entries] = base + stall + (gap ? GAP_LEN : 0);
      num_entries++;
    end
  endtask

  task automatic build_table();
    logic [31:0]   r;
    fm_op_e        op;
    fm_sign_mode_t mode;
    int            stall;
    // MUL corners
    add_entry("mul_zero", FM_OP_MUL, 2'b00, 32'h0000_0000, 32'h0000_0000, 0, 1'b0);
    add_entry("mul_one", FM_OP_MUL, 2'b11, 32'h0000_0001, 32'h0000_0001, 0, 1'b0);
    add_entry("mul_neg1_uu", FM_OP_MUL, 2'b00, 32'hffff_ffff, 32'hffff_ffff, 0, 1'b0);
    add_entry("mul_neg1_ss", FM_OP_MUL, 2'b11, 32'hffff_ffff, 32'hffff_ffff, 0, 1'b0);
    add_entry("mul_minneg_ss", FM_OP_MUL, 2'b11, 32'h8000_0000, 32'h8000_0000, 0, 1'b0);
    add_entry("mul_max_su", FM_OP_MUL, 2'b01, 32'h7fff_ffff, 32'hffff_ffff, 0, 1'b0);
    add_entry("mul_mixed_us", FM_OP_MUL, 2'b10, 32'h1234_5678, 32'h9abc_def0, 0, 1'b0);
    // MULH corners
    add_entry("mulh_minneg_ss", FM_OP_MULH, 2'b11, 32'h8000_0000, 32'h8000_0000, 0, 1'b0);
    add_entry("mulh_neg1_maxu_su", FM_OP_MULH, 2'b01, 32'hffff_ffff, 32'hffff_ffff, 0, 1'b0);
    add_entry("mulh_max_uu", FM_OP_MULH, 2'b00, 32'hffff_ffff, 32'hffff_ffff, 0, 1'b0);
    add_entry("mulh_neg1_ss", FM_OP_MULH, 2'b11, 32'hffff_ffff, 32'hffff_ffff, 0, 1'b0);
    add_entry("mulh_maxmin_ss", FM_OP_MULH, 2'b11, 32'h7fff_ffff, 32'h8000_0000, 0, 1'b0);
    add_entry("mulh_mixed_su", FM_OP_MULH, 2'b01, 32'h8000_0001, 32'hffff_fffe, 0, 1'b0);
    // Back-pressure at the final step
    add_entry("mul_stall1", FM_OP_MUL, 2'b11, 32'hdead_beef, 32'h1234_5678, 1, 1'b0);
    add_entry("mulh_stall3", FM_OP_MULH, 2'b01, 32'hcafe_f00d, 32'h8765_4321, 3, 1'b0);
    add_entry("mulh_stall5", FM_OP_MULH, 2'b11, 32'h8000_0000, 32'h7fff_ffff, MAX_STALL, 1'b0);
    // Enable dropped mid-operation
    add_entry("mul_gap", FM_OP_MUL, 2'b00, 32'h0bad_f00d, 32'h1357_9bdf, 0, 1'b1);
    add_entry("mulh_gap", FM_OP_MULH, 2'b11, 32'hfedc_ba98, 32'h7654_3210, 0, 1'b1);
    add_entry("mulh_gap_stall", FM_OP_MULH, 2'b01, 32'hffff_0000, 32'h0000_ffff, 2, 1'b1);

    for (int i = 0; i < NUM_RANDOM; i++) begin
      r    = $random(seed);
      op   = fm_op_e'(r[0]);
      mode = r[2:1];
      // MULHSU has no b-signed twin, so mode 10 becomes 11
      if (op == FM_OP_MULH && mode == 2'b10) begin
        mode = 2'b11;
      end
      stall = (i % 4 == 3) ? int'(r[6:4]) % (MAX_STALL + 1) : 0;
      add_entry($sformatf("rand_%0d", i), op, mode, $random(seed), $random(seed), stall,
                (i % 6 == 5));
    end
  endtask

  task automatic check_result(input string name, input fm_word_t exp_val,
                              input fm_word_t act_val);
    checks++;
    if (act_val !== exp_val) begin
      $display("ERROR %s: expected %h, actual %h", name, exp_val, act_val);
      result_errors++;
    end
  endtask

  task automatic check_cycles(input string name, input int exp_val, input int act_val);
    checks++;
    if (act_val != exp_val) begin
      $display("ERROR %s latency: expected %0d, actual %0d", name, exp_val, act_val);
      cycle_errors++;
    end
  endtask

  task automatic check_idle(input string when);
    checks++;
    if (valid_o !== 1'b0) begin
      $display("valid_o is high %s although no operation was started", when);
      protocol_errors++;
    end
  endtask

  // Issues one table entry and waits for its accepted result
  task automatic run_entry(input int idx);
    int       cycles;
    int       stalled;
    fm_word_t held;
    bit       done;
    cycles  = 0;
    stalled = 0;
    held    = '0;
    done    = 1'b0;

    @(posedge clk_i);
    #DRIVE_DLY;
    en_i        = 1'b1;
    op_i        = tbl_op[idx];
    sign_mode_i = tbl_mode[idx];
    op_a_i      = tbl_a[idx];
    op_b_i      = tbl_b[idx];
    ready_i     = (tbl_stall[idx] == 0);

    while (!done) begin
      @(negedge clk_i);
      cycles++;
      if (valid_o && !ready_i) begin
        if (stalled == 0) begin
          held = result_o;
        end else begin
          check_result({tbl_name[idx], "_hold"}, held, result_o);
        end
        stalled++;
      end else if (valid_o) begin
        check_result(tbl_name[idx], tbl_exp[idx], result_o);
        check_cycles(tbl_name[idx], tbl_cycles[idx], cycles);
        if (stalled > 0) begin
          check_result({tbl_name[idx], "_hold"}, held, result_o);
        end
        done = 1'b1;
      end else if (stalled > 0) begin
        $display("valid_o dropped while %s was waiting for ready_i", tbl_name[idx]);
        protocol_errors++;
        done = 1'b1;
      end

      if (!done) begin
        @(posedge clk_i);
        #DRIVE_DLY;
        // Gap covers the cycles after the first step
        if (tbl_gap[idx] && cycles == 1) begin
          en_i = 1'b0;
        end
        if (tbl_gap[idx] && cycles == 1 + GAP_LEN) begin
          en_i = 1'b1;
        end
        if (!ready_i && stalled >= tbl_stall[idx]) begin
          ready_i = 1'b1;
        end
      end
    end
  endtask

  initial begin : watchdog
    int limit;
    wait (table_ready);
    limit = num_entries * (`FM_MULH_CYCLES + MAX_STALL + 4) + 32;
    repeat (limit) @(posedge clk_i);
    $display("Timeout: the run did not finish within %0d clock cycles", limit);
    $display("Something failed");
    $finish;
  end

  initial begin : main
    clk_i           = 1'b0;
    rst_ni          = 1'b0;
    en_i            = 1'b0;
    ready_i         = 1'b1;
    op_i            = FM_OP_MUL;
    sign_mode_i     = 2'b00;
    op_a_i          = '0;
    op_b_i          = '0;
    seed            = 32'h500d81e7;
    num_entries     = 0;
    checks          = 0;
    result_errors   = 0;
    cycle_errors    = 0;
    protocol_errors = 0;

    build_table();
    table_ready = 1'b1;

    repeat (RESET_CYCLES) begin
      @(negedge clk_i);
      check_idle("during reset");
    end
    @(posedge clk_i);
    #DRIVE_DLY;
    rst_ni = 1'b1;
    repeat (3) begin
      @(negedge clk_i);
      check_idle("after reset");
    end

    // Enable stays high between entries, so issue is back-to-back
    for (int i = 0; i < num_entries; i++) begin
      run_entry(i);
    end

    @(posedge clk_i);
    #DRIVE_DLY;
    en_i    = 1'b0;
    ready_i = 1'b1;
    repeat (2) begin
      @(negedge clk_i);
      check_idle("after the last operation");
    end

    $display("%0d tests, %0d checks: %0d result errors, %0d latency errors, %0d protocol errors",
             num_entries, checks, result_errors, cycle_errors, protocol_errors);
    if (result_errors + cycle_errors + protocol_errors == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

// File: fastmul.f
+incdir+rtl
rtl/fastmul_pkg.sv
rtl/mult_sequencer.sv
rtl/mult_mac.sv
rtl/mult_accum.sv
rtl/fastmul_top.sv
bench/fastmul_tb.sv

// File: rtl/fastmul_pkg.sv
/*
 * Shared types of the iterative multiplier: data words, operator
 * encoding and the step code that the sequencer hands to the stages.
 */
`include "fastmul_settings.svh"

package fastmul_pkg;

  // Operand or result word
  typedef logic [`FM_WORD_W-1:0] fm_word_t;

  // Intermediate value, also the width of the MAC result
  typedef logic [`FM_ACC_W-1:0] fm_acc_t;

  // Bit 0 marks operand a as signed, bit 1 operand b
  typedef logic [1:0] fm_sign_mode_t;

  // MUL returns the low product word, MULH the high word
  typedef enum logic {
    FM_OP_MUL,
    FM_OP_MULH
  } fm_op_e;

  // Current partial product, with the operator folded in
  // LO variants pack the low word, HI variants keep the full sum
  typedef enum logic [2:0] {
    STEP_ALBL,
    STEP_ALBH_LO,
    STEP_ALBH_HI,
    // Last step of MUL
    STEP_AHBL_LO,
    STEP_AHBL_HI,
    // Last step of MULH
    STEP_AHBH
  } fm_step_e;

endpackage

// File: rtl/fastmul_settings.svh
/*
 * Width and latency settings of the iterative multiplier.
 * Included by the package, the RTL stages and the testbench.
 */
`ifndef FASTMUL_SETTINGS_SVH
`define FASTMUL_SETTINGS_SVH

// Operand and result width
`define FM_WORD_W 32
// Half-word processed per step
`define FM_HALF_W 16
// Intermediate register and MAC width
`define FM_ACC_W 34

// Cycles from first enable to valid
`define FM_MUL_CYCLES 3
`define FM_MULH_CYCLES 4

`endif

// File: rtl/fastmul_top.sv
/*
 * Iterative 32-bit multiplier for the RV32M MUL and MULH family.
 * Hold en_i and the operands until valid_o is seen with ready_i high.
 */
module fastmul_top
  import fastmul_pkg::*;
(
  input  logic          clk_i,
  input  logic          rst_ni,
  input  logic          en_i,
  input  logic          ready_i,
  input  fm_op_e        op_i,
  input  fm_sign_mode_t sign_mode_i,
  input  fm_word_t      op_a_i,
  input  fm_word_t      op_b_i,
  output fm_word_t      result_o,
  output logic          valid_o
);

  fm_step_e step;
  logic     advance;
  fm_acc_t  addend;
  fm_acc_t  mac_res;

  // Step control and back-pressure
  mult_sequencer u_sequencer (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .en_i     (en_i),
    .op_i     (op_i),
    .ready_i  (ready_i),
    .step_o   (step),
    .advance_o(advance),
    .valid_o  (valid_o)
  );

  mult_mac u_mac (
    .step_i     (step),
    .sign_mode_i(sign_mode_i),
    .op_a_i     (op_a_i),
    .op_b_i     (op_b_i),
    .addend_i   (addend),
    .mac_res_o  (mac_res)
  );

  // Intermediate register closes the loop around the MAC
  mult_accum u_accum (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .step_i     (step),
    .advance_i  (advance),
    .sign_mode_i(sign_mode_i),
    .mac_res_i  (mac_res),
    .addend_o   (addend),
    .result_o   (result_o)
  );

endmodule

// File: rtl/mult_accum.sv
/*
 * Accumulate stage of the iterative multiplier. Holds the intermediate
 * value, feeds the MAC its addend for each step and assembles the next
 * intermediate value, whose low word is the result.
 */
`include "fastmul_settings.svh"

module mult_accum
  import fastmul_pkg::*;
(
  input  logic          clk_i,
  input  logic          rst_ni,
  input  fm_step_e      step_i,
  input  logic          advance_i,
  input  fm_sign_mode_t sign_mode_i,
  input  fm_acc_t       mac_res_i,
  output fm_acc_t       addend_o,
  output fm_word_t      result_o
);

  fm_acc_t acc_q;
  fm_acc_t acc_d;
  logic    signed_mult;
  logic    lo_step;

  assign signed_mult = |sign_mode_i;

  // Addend per step and whether the low word is being packed
  always_comb begin
    addend_o = '0;
    lo_step  = 1'b0;

    case (step_i)
      STEP_ALBL: begin
        addend_o = '0;
      end
      STEP_ALBH_LO, STEP_AHBL_LO: begin
        // Carry the upper half of the running low word
        addend_o = {{(`FM_ACC_W - `FM_HALF_W){1'b0}}, acc_q[`FM_WORD_W-1:`FM_HALF_W]};
        lo_step  = 1'b1;
      end
      STEP_ALBH_HI: begin
        // AL*BL is unsigned without carry, so zero extension is exact
        addend_o = {{(`FM_ACC_W - `FM_HALF_W){1'b0}}, acc_q[`FM_WORD_W-1:`FM_HALF_W]};
      end
      STEP_AHBL_HI: begin
        addend_o = acc_q;
      end
      STEP_AHBH: begin
        // Sum of cross terms is only negative when a signed mode is set
        addend_o = {{`FM_HALF_W{signed_mult & acc_q[`FM_ACC_W-1]}},
                    acc_q[`FM_ACC_W-1:`FM_HALF_W]};
      end
      default: begin
        addend_o = '0;
      end
    endcase
  end

  // LO steps stack the new half above the stored low half
  assign acc_d = lo_step ?
      {{(`FM_ACC_W - `FM_WORD_W){1'b0}}, mac_res_i[`FM_HALF_W-1:0], acc_q[`FM_HALF_W-1:0]} :
      mac_res_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      acc_q <= '0;
    end else if (advance_i) begin
      acc_q <= acc_d;
    end
  end

  assign result_o = acc_d[`FM_WORD_W-1:0];

endmodule

// File: rtl/mult_mac.sv
/*
 * MAC stage of the iterative multiplier. Selects one half-word of each
 * operand for the current step and forms the 17x17 signed product plus
 * the addend from the accumulate stage. Purely combinational.
 */
`include "fastmul_settings.svh"

module mult_mac
  import fastmul_pkg::*;
(
  input  fm_step_e      step_i,
  input  fm_sign_mode_t sign_mode_i,
  input  fm_word_t      op_a_i,
  input  fm_word_t      op_b_i,
  input  fm_acc_t       addend_i,
  output fm_acc_t       mac_res_o
);

  logic                        sel_a_hi;
  logic                        sel_b_hi;
  logic [`FM_HALF_W-1:0]       half_a;
  logic [`FM_HALF_W-1:0]       half_b;
  logic                        sign_a;
  logic                        sign_b;
  logic signed [`FM_HALF_W:0]  mul_a;
  logic signed [`FM_HALF_W:0]  mul_b;
  logic signed [`FM_ACC_W-1:0] mac_sum;

  // Which half of each operand the step multiplies
  always_comb begin
    sel_a_hi = 1'b0;
    sel_b_hi = 1'b0;

    case (step_i)
      STEP_ALBL: begin
        sel_a_hi = 1'b0;
        sel_b_hi = 1'b0;
      end
      STEP_ALBH_LO, STEP_ALBH_HI: begin
        sel_a_hi = 1'b0;
        sel_b_hi = 1'b1;
      end
      STEP_AHBL_LO, STEP_AHBL_HI: begin
        sel_a_hi = 1'b1;
        sel_b_hi = 1'b0;
      end
      STEP_AHBH: begin
        sel_a_hi = 1'b1;
        sel_b_hi = 1'b1;
      end
      default: begin
        sel_a_hi = 1'b0;
        sel_b_hi = 1'b0;
      end
    endcase
  end

  assign half_a = sel_a_hi ? op_a_i[`FM_WORD_W-1:`FM_HALF_W] : op_a_i[`FM_HALF_W-1:0];
  assign half_b = sel_b_hi ? op_b_i[`FM_WORD_W-1:`FM_HALF_W] : op_b_i[`FM_HALF_W-1:0];

  // Low halves are always unsigned and a high half carries the operand sign
  assign sign_a = sel_a_hi & sign_mode_i[0] & op_a_i[`FM_WORD_W-1];
  assign sign_b = sel_b_hi & sign_mode_i[1] & op_b_i[`FM_WORD_W-1];

  assign mul_a = {sign_a, half_a};
  assign mul_b = {sign_b, half_b};

  // Both factors are 17 bit signed and the addend has equal upper bits,
  // so bit 34 of the full sum would only repeat bit 33
  assign mac_sum   = `FM_ACC_W'(mul_a) * `FM_ACC_W'(mul_b) + $signed(addend_i);
  assign mac_res_o = $unsigned(mac_sum);

endmodule

// File: rtl/mult_sequencer.sv
/*
 * Step sequencer of the iterative multiplier. Walks the partial products
 * one per enabled cycle, flags the last step as valid and holds it until
 * the consumer is ready.
 */
module mult_sequencer
  import fastmul_pkg::*;
(
  input  logic     clk_i,
  input  logic     rst_ni,
  input  logic     en_i,
  input  fm_op_e   op_i,
  input  logic     ready_i,
  output fm_step_e step_o,
  output logic     advance_o,
  output logic     valid_o
);

  // Position in the product, independent of the operator
  typedef enum logic [1:0] {
    PH_ALBL,
    PH_ALBH,
    PH_AHBL,
    PH_AHBH
  } phase_e;

  phase_e phase_q;
  phase_e phase_d;
  logic   final_step;
  logic   hold;

  // Decode phase and operator into the step code and the next phase
  always_comb begin
    phase_d    = phase_q;
    step_o     = STEP_ALBL;
    final_step = 1'b0;

    case (phase_q)
      PH_ALBL: begin
        step_o  = STEP_ALBL;
        phase_d = PH_ALBH;
      end

      PH_ALBH: begin
        if (op_i == FM_OP_MUL) begin
          step_o = STEP_ALBH_LO;
        end else begin
          step_o = STEP_ALBH_HI;
        end
        phase_d = PH_AHBL;
      end

      PH_AHBL: begin
        if (op_i == FM_OP_MUL) begin
          // MUL is complete after the cross terms
          step_o     = STEP_AHBL_LO;
          final_step = 1'b1;
          phase_d    = PH_ALBL;
        end else begin
          step_o  = STEP_AHBL_HI;
          phase_d = PH_AHBH;
        end
      end

      PH_AHBH: begin
        step_o     = STEP_AHBH;
        final_step = 1'b1;
        phase_d    = PH_ALBL;
      end

      default: begin
        phase_d = PH_ALBL;
      end
    endcase
  end

  assign valid_o = en_i & final_step;

  // The last step stays put until the result is taken
  assign hold      = valid_o & ~ready_i;
  assign advance_o = en_i & ~hold;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      phase_q <= PH_ALBL;
    end else if (advance_o) begin
      phase_q <= phase_d;
    end
  end

endmodule
